// File: apb_regs.sv
module apb_regs (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [demo_pkg::APB_AW-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output demo_pkg::render_cfg_t cfg,
	output logic start,
	output logic done,
	input logic busy,
	input logic [7:0] frame_count,
	input logic run_done
);

	logic wr_en;

	// no wait states
	assign pready = 1'b1;

	// writes land in the access phase
	assign wr_en = psel && penable && pwrite;

	// run bit is never stored, it only fires a pulse
	// a run request during a render is dropped
	assign start = wr_en && (paddr == demo_pkg::REG_CTRL) && pwdata[0] && !busy;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cfg <= '{effect_sel: 1'b0, tstep: 32'd0, frames: 8'd1};
			done <= 1'b0;
		end
		else
		begin
			if (wr_en)
			begin
				case (paddr)
					demo_pkg::REG_CTRL: cfg.effect_sel <= pwdata[1];
					demo_pkg::REG_TSTEP: cfg.tstep <= pwdata;
					// zero frames would never finish, hold it at one
					demo_pkg::REG_FRAMES: cfg.frames <= (pwdata[7:0] == 8'd0) ? 8'd1 : pwdata[7:0];
					default: ;
				endcase
			end
			// sticky done, set wins over a clear in the same cycle
			if (run_done)
				done <= 1'b1;
			else if (wr_en && (paddr == demo_pkg::REG_STATUS) && pwdata[1])
				done <= 1'b0;
		end
	end

	// read mux, ctrl run bit always reads back as 0
	always_comb
	begin
		prdata = 32'd0;
		if (psel)
		begin
			case (paddr)
				demo_pkg::REG_CTRL: prdata = {30'd0, cfg.effect_sel, 1'b0};
				demo_pkg::REG_TSTEP: prdata = cfg.tstep;
				demo_pkg::REG_FRAMES: prdata = {24'd0, cfg.frames};
				demo_pkg::REG_STATUS: prdata = {16'd0, frame_count, 6'd0, done, busy};
				default: prdata = 32'd0;
			endcase
		end
	end

	// setup phase must be followed by an access to the same address
	a_paddr_stable: assert property (@(posedge clk) disable iff (rst)
		(psel && !penable) |=> (psel && penable && $stable(paddr)));

endmodule

// File: delay_line.sv
module delay_line #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 1
) (
	input logic clk,
	input logic rst,
	input logic adv,
	input payload_t d,
	output payload_t q
);

	payload_t stage_q [DEPTH];

	// zero reset so a tag valid bit starts inactive
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
				stage_q[i] <= '0;
		end
		else if (adv)
		begin
			stage_q[0] <= d;
			for (int i = 1; i < DEPTH; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	assign q = stage_q[DEPTH-1];

endmodule

// File: demo_pkg.sv
package demo_pkg;

	// frame geometry, kept tiny so a full run fits in a short simulation
	localparam int IMG_W = 16;
	localparam int IMG_H = 8;
	localparam int COORD_W = 8;
	localparam int PIX_W = 32;
	localparam int APB_AW = 8;

	// last coordinate on each axis, in coordinate width
	localparam logic [COORD_W-1:0] X_LAST = COORD_W'(IMG_W - 1);
	localparam logic [COORD_W-1:0] Y_LAST = COORD_W'(IMG_H - 1);

	// pipeline depths in advance cycles
	localparam int STARS_LAT = 4;
	// 16 root stages plus the output add
	localparam int RING_LAT = 17;
	// stars result waits this long to line up with rings
	localparam int ALIGN_LAT = RING_LAT - STARS_LAT;
	localparam int PIPE_LAT = RING_LAT;

	// register map
	localparam logic [APB_AW-1:0] REG_CTRL = 8'h00;
	localparam logic [APB_AW-1:0] REG_TSTEP = 8'h04;
	localparam logic [APB_AW-1:0] REG_FRAMES = 8'h08;
	localparam logic [APB_AW-1:0] REG_STATUS = 8'h0C;

	// render sequencer states
	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		FRAME_END,
		DONE
	} seq_state_t;

	// sideband that follows each pixel down the pipeline
	typedef struct packed {
		logic valid;
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		logic last_in_frame;
		logic last_of_run;
	} pixel_tag_t;

	// configuration bundle written over apb
	typedef struct packed {
		logic effect_sel;
		logic [31:0] tstep;
		logic [7:0] frames;
	} render_cfg_t;

endpackage

// File: effect_top.sv
module effect_top (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [demo_pkg::APB_AW-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic out_valid,
	input logic out_ready,
	output logic [demo_pkg::COORD_W-1:0] out_x,
	output logic [demo_pkg::COORD_W-1:0] out_y,
	output logic out_last_frame,
	output logic out_last_run,
	output logic [demo_pkg::PIX_W-1:0] out_data,
	output logic irq
);

	demo_pkg::render_cfg_t cfg;
	demo_pkg::pixel_tag_t tag_out;
	logic start;
	logic done;
	logic busy;
	logic [7:0] frame_count;
	logic run_done;
	logic scan_en;
	logic frame_start;
	logic advance_time;
	logic last_frame;
	logic frame_done;
	logic adv;
	logic [demo_pkg::PIX_W-1:0] stars_val;
	logic [demo_pkg::PIX_W-1:0] stars_dly;
	logic [demo_pkg::PIX_W-1:0] ring_val;

	pix_if pix ();

	// single global stall, the whole chain freezes while the output pixel waits
	assign adv = !(out_valid && !out_ready);
	assign pix.adv = adv;

	apb_regs regs_i (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.pready, .cfg, .start, .done, .busy, .frame_count, .run_done);

	render_sequencer seq_i (.clk, .rst, .start, .cfg, .frame_done, .adv, .scan_en,
		.frame_start, .advance_time, .last_frame, .busy, .frame_count, .run_done);

	raster_timer timer_i (.clk, .rst, .scan_en, .frame_start, .advance_time, .last_frame,
		.tstep(cfg.tstep), .frame_done, .issue(pix.issue));

	stars_texture stars_i (.clk, .rst, .adv, .x(pix.tag.x), .y(pix.tag.y), .t(pix.t),
		.value(stars_val));

	isqrt_pipe rings_i (.clk, .rst, .adv, .x(pix.tag.x), .y(pix.tag.y), .t(pix.t),
		.value(ring_val));

	// short stars path padded out to the rings depth
	delay_line #(.payload_t(logic [demo_pkg::PIX_W-1:0]), .DEPTH(demo_pkg::ALIGN_LAT))
		stars_dly_i (.clk, .rst, .adv, .d(stars_val), .q(stars_dly));

	// coordinate sideband, same depth as the longest texture
	delay_line #(.payload_t(demo_pkg::pixel_tag_t), .DEPTH(demo_pkg::PIPE_LAT))
		tag_dly_i (.clk, .rst, .adv, .d(pix.tag), .q(tag_out));

	// output stage is the last register of each delay path
	assign out_valid = tag_out.valid;
	assign out_x = tag_out.x;
	assign out_y = tag_out.y;
	assign out_last_frame = tag_out.last_in_frame;
	assign out_last_run = tag_out.last_of_run;
	assign out_data = cfg.effect_sel ? ring_val : stars_dly;
	assign irq = done;

endmodule

// File: isqrt_pipe.sv
module isqrt_pipe (
	input logic clk,
	input logic rst,
	input logic adv,
	input logic [demo_pkg::COORD_W-1:0] x,
	input logic [demo_pkg::COORD_W-1:0] y,
	input logic [31:0] t,
	output logic [demo_pkg::PIX_W-1:0] value
);

	localparam int ROOT_STAGES = demo_pkg::RING_LAT - 1;
	localparam int REM_W = 20;

	// one stage of the digit by digit root
	typedef struct packed {
		logic [31:0] rad;
		logic [REM_W-1:0] rem;
		logic [15:0] root;
	} sq_t;

	logic signed [31:0] dx;
	logic signed [31:0] dy;
	logic [31:0] d2;
	sq_t sq_in;
	sq_t sq_q [ROOT_STAGES];
	logic [31:0] t_q [ROOT_STAGES];

	// brings in the next two radicand bits and tries to set the next root bit
	function automatic sq_t root_step(input sq_t s);
		sq_t r;
		logic [REM_W-1:0] rem_sh;
		logic [REM_W-1:0] trial;
		rem_sh = {s.rem[REM_W-3:0], s.rad[31:30]};
		trial = REM_W'({s.root, 2'b01});
		r.rad = s.rad << 2;
		if (rem_sh >= trial)
		begin
			r.rem = rem_sh - trial;
			r.root = {s.root[14:0], 1'b1};
		end
		else
		begin
			r.rem = rem_sh;
			r.root = {s.root[14:0], 1'b0};
		end
		return r;
	endfunction

	// squared distance from the frame centre
	assign dx = signed'({{(32 - demo_pkg::COORD_W){1'b0}}, x}) - (demo_pkg::IMG_W / 2);
	assign dy = signed'({{(32 - demo_pkg::COORD_W){1'b0}}, y}) - (demo_pkg::IMG_H / 2);
	assign d2 = dx * dx + dy * dy;
	assign sq_in = '{rad: d2, rem: '0, root: 16'd0};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < ROOT_STAGES; i++)
			begin
				sq_q[i] <= '0;
				t_q[i] <= 32'd0;
			end
			value <= '0;
		end
		else if (adv)
		begin
			sq_q[0] <= root_step(sq_in);
			t_q[0] <= t;
			for (int i = 1; i < ROOT_STAGES; i++)
			begin
				sq_q[i] <= root_step(sq_q[i-1]);
				// time rides along with its pixel
				t_q[i] <= t_q[i-1];
			end
			// rings move outward as time grows
			value <= ({16'd0, sq_q[ROOT_STAGES-1].root} << 4) + (t_q[ROOT_STAGES-1] >> 8);
		end
	end

endmodule

// File: pix_if.sv
interface pix_if;

	// coordinate tag as issued by the raster timer
	demo_pkg::pixel_tag_t tag;
	// frame time that belongs to the issued coordinate
	logic [31:0] t;
	// global advance, low while the output pixel is held
	logic adv;

	// producer side, the timer
	modport issue (
		output tag,
		output t,
		input adv
	);

	// consumer side, the texture pipelines and the output stage
	modport sink (
		input tag,
		input t,
		input adv
	);

endinterface

// File: raster_timer.sv
module raster_timer (
	input logic clk,
	input logic rst,
	input logic scan_en,
	input logic frame_start,
	input logic advance_time,
	input logic last_frame,
	input logic [31:0] tstep,
	output logic frame_done,
	pix_if.issue issue
);

	logic [demo_pkg::COORD_W-1:0] x_cnt;
	logic [demo_pkg::COORD_W-1:0] y_cnt;
	logic at_last;

	assign at_last = (x_cnt == demo_pkg::X_LAST) && (y_cnt == demo_pkg::Y_LAST);

	// pulse on the cycle the final coordinate of the frame issues
	assign frame_done = issue.adv && scan_en && at_last;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			x_cnt <= '0;
			y_cnt <= '0;
			issue.t <= 32'd0;
			issue.tag <= '0;
		end
		else
		begin
			// issue register, a bubble when the sequencer is not scanning
			if (issue.adv)
			begin
				if (scan_en)
				begin
					issue.tag.valid <= 1'b1;
					issue.tag.x <= x_cnt;
					issue.tag.y <= y_cnt;
					issue.tag.last_in_frame <= at_last;
					// last_frame from the sequencer is valid alongside frame_done
					issue.tag.last_of_run <= at_last && last_frame;
				end
				else
					issue.tag.valid <= 1'b0;
			end
			if (frame_start)
			begin
				x_cnt <= '0;
				y_cnt <= '0;
				issue.t <= 32'd0;
			end
			else if (issue.adv)
			begin
				// frame time steps once per frame, in the FRAME_END gap
				if (advance_time)
					issue.t <= issue.t + tstep;
				// raster order, x fastest
				if (scan_en)
				begin
					if (x_cnt == demo_pkg::X_LAST)
					begin
						x_cnt <= '0;
						y_cnt <= (y_cnt == demo_pkg::Y_LAST) ? '0 : y_cnt + 1'b1;
					end
					else
						x_cnt <= x_cnt + 1'b1;
				end
			end
		end
	end

	a_coord_in_frame: assert property (@(posedge clk) disable iff (rst)
		issue.tag.valid |-> (issue.tag.x < demo_pkg::IMG_W) && (issue.tag.y < demo_pkg::IMG_H));

endmodule

// File: render_sequencer.sv
module render_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input demo_pkg::render_cfg_t cfg,
	input logic frame_done,
	input logic adv,
	output logic scan_en,
	output logic frame_start,
	output logic advance_time,
	output logic last_frame,
	output logic busy,
	output logic [7:0] frame_count,
	output logic run_done
);

	demo_pkg::seq_state_t state;
	demo_pkg::seq_state_t state_nxt;
	logic [7:0] count_nxt;

	assign count_nxt = frame_count + 8'd1;

	// timer only issues in SCAN, so FRAME_END is a clean gap for the time update
	assign scan_en = (state == demo_pkg::SCAN);
	assign advance_time = (state == demo_pkg::FRAME_END);
	// clears the timer counters and time at the start of a run
	assign frame_start = start && (state == demo_pkg::IDLE);
	// current frame is the final one, the timer samples this with frame_done
	assign last_frame = (count_nxt == cfg.frames);
	assign run_done = (state == demo_pkg::DONE);

	always_comb
	begin
		state_nxt = state;
		case (state)
			demo_pkg::IDLE:
				if (start)
					state_nxt = demo_pkg::SCAN;
			demo_pkg::SCAN:
				if (frame_done)
					state_nxt = demo_pkg::FRAME_END;
			// leave only on an advancing cycle so the time step lines up with the tag
			demo_pkg::FRAME_END:
				if (adv)
					state_nxt = last_frame ? demo_pkg::DONE : demo_pkg::SCAN;
			demo_pkg::DONE:
				state_nxt = demo_pkg::IDLE;
			default:
				state_nxt = demo_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= demo_pkg::IDLE;
			frame_count <= 8'd0;
			busy <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (frame_start)
			begin
				frame_count <= 8'd0;
				busy <= 1'b1;
			end
			else if ((state == demo_pkg::FRAME_END) && adv)
			begin
				frame_count <= count_nxt;
				// busy drops as DONE is entered
				if (last_frame)
					busy <= 1'b0;
			end
		end
	end

	// busy is registered apart from the state, so the two must agree in DONE
	a_done_not_busy: assert property (@(posedge clk) disable iff (rst)
		(state == demo_pkg::DONE) |-> !busy);

endmodule

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_effect -f src.f \
	-o tb_effect > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_effect > sim.log 2>&1
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// File: src.f
demo_pkg.sv
pix_if.sv
apb_regs.sv
render_sequencer.sv
raster_timer.sv
stars_texture.sv
isqrt_pipe.sv
delay_line.sv
effect_top.sv
tb_effect.sv

// File: stars_texture.sv
module stars_texture (
	input logic clk,
	input logic rst,
	input logic adv,
	input logic [demo_pkg::COORD_W-1:0] x,
	input logic [demo_pkg::COORD_W-1:0] y,
	input logic [31:0] t,
	output logic [demo_pkg::PIX_W-1:0] value
);

	logic [31:0] x32;
	logic [31:0] y32;
	logic [31:0] mix_x;
	logic [31:0] mix_y;
	logic [31:0] r1;
	logic [31:0] r2;
	logic [31:0] r3;

	assign x32 = {{(32 - demo_pkg::COORD_W){1'b0}}, x};
	assign y32 = {{(32 - demo_pkg::COORD_W){1'b0}}, y};

	// x drifts with the slow part of the time, y folds its own high byte back in
	assign mix_x = (x32 + {12'd0, t[31:12]}) >> 7;
	assign mix_y = (y32 >> 8) + y32;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			r1 <= 32'd0;
			r2 <= 32'd0;
			r3 <= 32'd0;
			value <= '0;
		end
		else if (adv)
		begin
			// stage 1, multiplicative hash of the two axes
			r1 <= mix_x * 32'd11713 + mix_y * 32'd5422133;
			// stage 2, second mixing round
			r2 <= r1 * 32'd7 + (r1 >> 8) * 32'd1817;
			// stage 3, byte shuffle with an xor of all four bytes at the bottom
			r3 <= {r2[7:0], r2[15:8], r2[23:16], r2[7:0] ^ r2[15:8] ^ r2[23:16] ^ r2[31:24]};
			// stage 4, sparse threshold
			// only words with a zero low byte survive, bit 8 picks white or the raw hash
			if (r3[7:0] != 8'd0)
				value <= '0;
			else if (r3[8])
				value <= '1;
			else
				value <= r3;
		end
	end

endmodule

// File: tb_effect.sv
module tb_effect;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FRAME_PIX = demo_pkg::IMG_W * demo_pkg::IMG_H;
	// bounds on every wait, in clock cycles
	localparam int APB_LIMIT = 16;
	localparam int RUN_LIMIT = 4000;
	localparam int DRAIN_LIMIT = 400;

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [demo_pkg::APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic out_valid;
	logic out_ready = 1'b0;
	logic [demo_pkg::COORD_W-1:0] out_x;
	logic [demo_pkg::COORD_W-1:0] out_y;
	logic out_last_frame;
	logic out_last_run;
	logic [demo_pkg::PIX_W-1:0] out_data;
	logic irq;

	integer seed = 73;
	int errors = 0;
	bit stalled = 1'b0;
	// pixels taken since reset, and the count where the current run began
	int accepted;
	int run_base = 0;
	int run_pixels = 0;
	logic sel_cfg = 1'b0;
	logic [31:0] tstep_cfg = 32'd0;
	int frames_cfg = 1;

	// expected raster position, derived from the number of pixels taken
	int idx;
	int exp_frame;
	logic [demo_pkg::COORD_W-1:0] exp_x;
	logic [demo_pkg::COORD_W-1:0] exp_y;
	logic [31:0] exp_t;
	logic exp_end;
	logic [31:0] exp_data;
	logic accept;
	// output as seen at the previous rising edge
	logic [31:0] prev_data;
	logic [demo_pkg::COORD_W-1:0] prev_x;
	logic [demo_pkg::COORD_W-1:0] prev_y;

	effect_top dut_i (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
		.out_valid, .out_ready, .out_x, .out_y, .out_last_frame, .out_last_run, .out_data, .irq);

	always #20 clk = ~clk;

	// hash texture: mix, second round, byte shuffle, sparse threshold
	function automatic logic [31:0] stars_model(input logic [7:0] x, input logic [7:0] y,
		input logic [31:0] t);
		logic [31:0] h;
		logic [31:0] m;
		logic [7:0] fold;
		h = ((32'(x) + (t >> 12)) >> 7) * 32'd11713 + (32'(y) + (32'(y) >> 8)) * 32'd5422133;
		h = h * 32'd7 + (h >> 8) * 32'd1817;
		fold = h[7:0] ^ h[15:8] ^ h[23:16] ^ h[31:24];
		m = {h[7:0], h[15:8], h[23:16], fold};
		if (fold != 8'd0)
			m = 32'd0;
		else if (m[8])
			m = 32'hFFFF_FFFF;
		return m;
	endfunction

	// distance from the centre, rounded down, then shifted by time
	function automatic logic [31:0] ring_model(input logic [7:0] x, input logic [7:0] y,
		input logic [31:0] t);
		int dx;
		int dy;
		int d2;
		int r;
		dx = int'(x) - demo_pkg::IMG_W / 2;
		dy = int'(y) - demo_pkg::IMG_H / 2;
		d2 = dx * dx + dy * dy;
		r = 0;
		while ((r + 1) * (r + 1) <= d2)
			r = r + 1;
		return 32'(r) * 32'd16 + (t >> 8);
	endfunction

	assign accept = out_valid && out_ready;
	assign idx = accepted - run_base;
	assign exp_x = demo_pkg::COORD_W'(idx % demo_pkg::IMG_W);
	assign exp_y = demo_pkg::COORD_W'((idx / demo_pkg::IMG_W) % demo_pkg::IMG_H);
	assign exp_frame = idx / FRAME_PIX;
	// frame k runs at time k times the step
	assign exp_t = tstep_cfg * 32'(exp_frame);
	assign exp_end = (exp_x == demo_pkg::IMG_W - 1) && (exp_y == demo_pkg::IMG_H - 1);
	assign exp_data = sel_cfg ? ring_model(exp_x, exp_y, exp_t) : stars_model(exp_x, exp_y, exp_t);

	always @(posedge clk or posedge rst)
	begin
		if (rst)
			accepted <= 0;
		else if (accept)
			accepted <= accepted + 1;
		prev_data <= out_data;
		prev_x <= out_x;
		prev_y <= out_y;
	end

	// sink takes about seven pixels in ten
	always @(negedge clk)
	begin
		if (rst)
			out_ready = 1'b0;
		else
			out_ready = ($unsigned($random(seed)) % 10) < 7;
	end

	a_position: assert property (@(posedge clk) disable iff (rst)
		accept |-> (out_x == exp_x) && (out_y == exp_y))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] %0t out_x,out_y expected %0d,%0d got %0d,%0d", $time,
			$sampled(exp_x), $sampled(exp_y), $sampled(out_x), $sampled(out_y));
	end

	a_data: assert property (@(posedge clk) disable iff (rst) accept |-> out_data == exp_data)
	else
	begin
		errors = errors + 1;
		$display("[ERROR] %0t out_data expected %h got %h", $time, $sampled(exp_data),
			$sampled(out_data));
	end

	a_last_frame: assert property (@(posedge clk) disable iff (rst)
		accept |-> out_last_frame == exp_end)
	else
	begin
		errors = errors + 1;
		$display("[ERROR] %0t out_last_frame expected %b got %b", $time, $sampled(exp_end),
			$sampled(out_last_frame));
	end

	// only the final pixel of the final frame closes the run
	a_last_run: assert property (@(posedge clk) disable iff (rst)
		accept |-> out_last_run == (exp_end && (exp_frame == frames_cfg - 1)))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] %0t out_last_run expected %b got %b", $time,
			$sampled(exp_end && (exp_frame == frames_cfg - 1)), $sampled(out_last_run));
	end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=>
		out_valid && (out_data == prev_data) && (out_x == prev_x) && (out_y == prev_y))
	else
	begin
		errors = errors + 1;
		$display("[ERROR] %0t held out_data expected %h got %h, out_x,out_y expected %0d,%0d got %0d,%0d",
			$time, $sampled(prev_data), $sampled(out_data), $sampled(prev_x), $sampled(prev_y),
			$sampled(out_x), $sampled(out_y));
	end

	a_no_extra: assert property (@(posedge clk) disable iff (rst) out_valid |-> idx < run_pixels)
	else
	begin
		errors = errors + 1;
		$display("%0t a pixel came out although the run had already delivered all of its pixels",
			$time);
	end

	task automatic report_stall(input string what);
		stalled = 1'b1;
		errors = errors + 1;
		$display("%0t stall: %s", $time, what);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		int n;
		if (stalled)
			return;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		n = 0;
		while (!pready && n < APB_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!pready)
			report_stall("APB write never saw pready");
		// transfer completes at the rising edge in between
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		data = 32'd0;
		if (stalled)
			return;
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		n = 0;
		while (!pready && n < APB_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!pready)
			report_stall("APB read never saw pready");
		data = prdata;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		apb_read(addr, got);
		if (stalled)
			return;
		assert (got == exp)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// one full render, then the done handshake
	task automatic run_frames(input logic sel, input logic [31:0] tstep, input int frames);
		int n;
		if (stalled)
			return;
		sel_cfg = sel;
		tstep_cfg = tstep;
		frames_cfg = frames;
		run_base = accepted;
		run_pixels = frames * FRAME_PIX;
		apb_write(demo_pkg::REG_TSTEP, tstep);
		apb_write(demo_pkg::REG_FRAMES, 32'(frames));
		apb_write(demo_pkg::REG_CTRL, {30'd0, sel, 1'b1});
		n = 0;
		while (!irq && n < RUN_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!irq)
		begin
			report_stall("the render never finished, irq did not rise");
			return;
		end
		// irq comes before the pipeline has drained
		n = 0;
		while (idx < run_pixels && n < DRAIN_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (idx < run_pixels)
		begin
			report_stall("the pixel stream stopped before the run was complete");
			return;
		end
		// quiet gap where a repeated pixel would be caught
		repeat (40) @(negedge clk);
		check_reg("status after run", demo_pkg::REG_STATUS, {16'd0, 8'(frames), 6'd0, 2'b10});
		apb_write(demo_pkg::REG_STATUS, 32'h2);
		assert (irq == 1'b0)
		else
		begin
			errors = errors + 1;
			$display("[ERROR] %0t irq expected 0 got %b", $time, irq);
		end
		check_reg("status after clear", demo_pkg::REG_STATUS, {16'd0, 8'(frames), 8'd0});
	endtask

	initial
	begin
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = 32'd0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_reg("status after reset", demo_pkg::REG_STATUS, 32'd0);
		apb_write(demo_pkg::REG_TSTEP, 32'hA5C3_0F96);
		check_reg("tstep", demo_pkg::REG_TSTEP, 32'hA5C3_0F96);
		apb_write(demo_pkg::REG_FRAMES, 32'h5);
		check_reg("frames", demo_pkg::REG_FRAMES, 32'h5);
		// select bit only, run stays clear
		apb_write(demo_pkg::REG_CTRL, 32'h2);
		check_reg("ctrl", demo_pkg::REG_CTRL, 32'h2);
		apb_write(demo_pkg::REG_CTRL, 32'h0);
		check_reg("ctrl", demo_pkg::REG_CTRL, 32'h0);
		// large step so the stars drift between frames
		run_frames(1'b0, 32'h0008_0000, 2);
		run_frames(1'b1, 32'h0000_0300, 2);
		$display("checks finished: %0d pixels accepted, %0d errors", accepted, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
